/* filelist.f */
logic/riscv_pkg.sv
logic/obi_intf.sv
logic/lsu_align.sv
logic/lsu.sv
logic/obi_sram.sv
logic/lsu_subsys.sv
test/tb_lsu_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the LSU subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_lsu_subsys \
    --Mdir obj_dir \
    -o sim_tb && \
./obj_dir/sim_tb | tee "$LOG" || { echo "build or run failed"; exit 1; }

grep -q "^>>> PASS$" "$LOG" && {
    echo "simulation passed"
    exit 0
} || {
    echo "simulation failed"
    exit 1
}

/* test/tb_lsu_subsys.sv */
module tb_lsu_subsys import riscv_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int GNT_DELAY = 2;
    // Prefill 32, word 6, lanes 16, held 4, disabled 2, random 60
    localparam int N_ACCESS  = 32 + 6 + 16 + 4 + 2 + 60;
    localparam int TIMEOUT   = 40 * N_ACCESS + 16;

    logic            CLK;
    logic            RSTn;
    logic            data_req;
    logic            mem_en;
    logic            mem_wr;
    mem_size_t       mem_size;
    logic            mem_unsigned;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            busy;
    logic [XLEN-1:0] rdata;

    logic [7:0]      ref_mem [0:1023];               // Byte image of the RAM
    logic [31:0]     lfsr = 32'h1d17_1bdd;
    int              cycle_cnt = 0;
    int              busy_run = 0;
    int              fail_count = 0;

    lsu_subsys #(
        .GNT_DELAY (GNT_DELAY),
        .MEM_WORDS (256)
    ) dut0 (
        .CLK          (CLK),
        .RSTn         (RSTn),
        .data_req     (data_req),
        .mem_en       (mem_en),
        .mem_wr       (mem_wr),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .addr         (addr),
        .wdata        (wdata),
        .busy         (busy),
        .rdata        (rdata)
    );

    always #50 CLK = ~CLK;

    // ############################################################
    // Failure reporting and run limit

    task automatic report_fail(input string msg);
        fail_count++;
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            report_fail($sformatf("FAIL %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            report_fail("simulation timed out");
        end
    end

    // An access needs GNT_DELAY + 1 busy cycles before its response
    always @(negedge CLK) begin
        if (RSTn && busy) begin
            busy_run++;
        end else begin
            if (RSTn && busy_run != 0) begin
                assert (busy_run >= GNT_DELAY + 1) else begin
                    report_fail($sformatf("busy fell after %0d cycles, before the access completed",
                                          busy_run));
                end
            end
            busy_run = 0;
        end
    end

    a_idle_not_busy : assert property (@(posedge CLK) disable iff (!RSTn)
        (!data_req || !mem_en) |-> !busy)
        else report_fail("busy was high without an enabled request");

    // ############################################################
    // Stimulus helpers

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a0f_c3e1;
    endfunction

    function automatic void ref_store(logic [31:0] a, mem_size_t size, logic [31:0] d);
        int n;
        n = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a[9:0] + 10'(i)] = d[8*i +: 8];  // Little endian lanes
        end
    endfunction

    function automatic logic [31:0] ref_load(logic [31:0] a, mem_size_t size, logic uns);
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [31:0] w;
        b0 = ref_mem[a[9:0]];
        b1 = ref_mem[a[9:0] + 10'd1];
        case (size)
            SIZE_BYTE: w = uns ? {24'd0, b0} : {{24{b0[7]}}, b0};
            SIZE_HALF: w = uns ? {16'd0, b1, b0} : {{16{b1[7]}}, b1, b0};
            default:   w = {ref_mem[a[9:0] + 10'd3], ref_mem[a[9:0] + 10'd2], b1, b0};
        endcase
        return w;
    endfunction

    // Called 10 ns after a rising edge, returns at the same point
    task automatic do_access(input string name, input logic wr, input mem_size_t size,
                             input logic uns, input logic [31:0] a, input logic [31:0] d);
        logic [31:0] exp;
        data_req     = 1'b1;
        mem_en       = 1'b1;
        mem_wr       = wr;
        mem_size     = size;
        mem_unsigned = uns;
        addr         = a;
        wdata        = d;
        @(negedge CLK);
        assert (busy) else report_fail($sformatf("%s: busy did not rise on the request", name));
        while (busy) begin
            @(negedge CLK);
        end
        @(posedge CLK);                              // Load result lands here
        #10;
        data_req = 1'b0;
        mem_en   = 1'b0;
        if (wr) begin
            ref_store(a, size, d);
        end else begin
            exp = ref_load(a, size, uns);
            check_value(name, exp, rdata);
        end
    endtask

    // ############################################################
    // Tests

    initial begin
        logic [31:0] bits;
        logic [31:0] a;
        logic        wr_bit;
        logic        uns_bit;
        mem_size_t   sz;

        CLK          = 1'b0;
        RSTn         = 1'b0;
        data_req     = 1'b0;
        mem_en       = 1'b0;
        mem_wr       = 1'b0;
        mem_size     = SIZE_WORD;
        mem_unsigned = 1'b0;
        addr         = '0;
        wdata        = '0;
        repeat (16) @(posedge CLK);
        #10;
        RSTn = 1'b1;

        // Idle after reset
        repeat (4) begin
            @(negedge CLK);
            check_value("reset busy", 32'd0, {31'd0, busy});
            check_value("reset rdata", 32'd0, rdata);
        end
        @(posedge CLK);
        #10;

        for (int w = 0; w < 32; w++) begin
            a = 32'(w) << 2;
            do_access($sformatf("prefill %0d", w), 1'b1, SIZE_WORD, 1'b0, a, fill_word(a));
        end

        // Word store and load, independent addresses
        do_access("word store 10", 1'b1, SIZE_WORD, 1'b0, 32'h10, 32'h0bad_f00d);
        do_access("word store 14", 1'b1, SIZE_WORD, 1'b0, 32'h14, 32'h7654_3210);
        do_access("word store 7c", 1'b1, SIZE_WORD, 1'b0, 32'h7c, 32'hfedc_ba98);
        do_access("word load 10", 1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h0);
        do_access("word load 14", 1'b0, SIZE_WORD, 1'b0, 32'h14, 32'h0);
        do_access("word load 7c", 1'b0, SIZE_WORD, 1'b0, 32'h7c, 32'h0);

        // Lanes of one word
        do_access("lane word store", 1'b1, SIZE_WORD, 1'b0, 32'h30, 32'h1234_5678);
        do_access("lane byte store", 1'b1, SIZE_BYTE, 1'b0, 32'h31, 32'h0000_00a5);
        do_access("lane half store", 1'b1, SIZE_HALF, 1'b0, 32'h32, 32'h0000_8001);
        for (int off = 0; off < 4; off++) begin
            do_access("lane byte signed", 1'b0, SIZE_BYTE, 1'b0, 32'h30 + 32'(off), 32'h0);
            do_access("lane byte unsigned", 1'b0, SIZE_BYTE, 1'b1, 32'h30 + 32'(off), 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_access("lane half signed", 1'b0, SIZE_HALF, 1'b0, 32'h30 + 32'(off), 32'h0);
            do_access("lane half unsigned", 1'b0, SIZE_HALF, 1'b1, 32'h30 + 32'(off), 32'h0);
        end
        do_access("lane word load", 1'b0, SIZE_WORD, 1'b0, 32'h30, 32'h0);
        check_value("lane word value", 32'h8001_a578, rdata);

        // Held inputs under the grant delay
        do_access("held store 20", 1'b1, SIZE_WORD, 1'b0, 32'h20, 32'h1111_2222);
        do_access("held store 24", 1'b1, SIZE_WORD, 1'b0, 32'h24, 32'h3333_4444);
        do_access("held load 24", 1'b0, SIZE_WORD, 1'b0, 32'h24, 32'h0);
        check_value("held value 24", 32'h3333_4444, rdata);
        do_access("held load 20", 1'b0, SIZE_WORD, 1'b0, 32'h20, 32'h0);
        check_value("held value 20", 32'h1111_2222, rdata);

        // Request without mem_en must not start a store
        data_req = 1'b1;
        mem_wr   = 1'b1;
        mem_size = SIZE_WORD;
        addr     = 32'h10;
        wdata    = 32'hdead_beef;
        repeat (5) begin
            @(negedge CLK);
            check_value("disabled busy", 32'd0, {31'd0, busy});
        end
        @(posedge CLK);
        #10;
        data_req = 1'b0;
        do_access("disabled load 10", 1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h0);
        check_value("disabled value 10", 32'h0bad_f00d, rdata);

        for (int i = 0; i < 60; i++) begin
            bits = rand_bits(2);
            sz   = (bits[1:0] == 2'b11) ? SIZE_WORD : mem_size_t'(bits[1:0]);
            bits = rand_bits(5);
            a    = {25'd0, bits[4:0], 2'b00};
            if (sz == SIZE_BYTE) begin
                bits    = rand_bits(2);
                a[1:0]  = bits[1:0];
            end else if (sz == SIZE_HALF) begin
                bits    = rand_bits(1);
                a[1]    = bits[0];
            end
            bits    = rand_bits(1);
            wr_bit  = bits[0];
            bits    = rand_bits(1);
            uns_bit = bits[0];
            bits    = rand_bits(32);
            do_access($sformatf("random %0d", i), wr_bit, sz, uns_bit, a, bits);
        end

        if (fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_fail("one or more checks failed");
        end
    end

endmodule

/* logic/lsu_subsys.sv */
module lsu_subsys import riscv_pkg::*; #(
    parameter int GNT_DELAY = 2,
    parameter int MEM_WORDS = 256
) (
    input  logic            CLK,
    input  logic            RSTn,

    // Memory stage
    input  logic            data_req,
    input  logic            mem_en,
    input  logic            mem_wr,
    input  mem_size_t       mem_size,
    input  logic            mem_unsigned,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,

    output logic            busy,
    output logic [XLEN-1:0] rdata
);

    MEM_ctrl mem_ctrl;

    assign mem_ctrl = '{
        mem_en:      mem_en,
        wr:          mem_wr,
        size:        mem_size,
        unsigned_ld: mem_unsigned
    };

    obi_intf bus0 ();

    lsu lsu0 (
        .CLK         (CLK),
        .RSTn        (RSTn),
        .HZ_data_req (data_req),
        .MEM_ctrl_in (mem_ctrl),
        .addr_in     (addr),
        .data_in     (wdata),
        .busy_out    (busy),
        .data_out    (rdata),
        .lsu_intf    (bus0)
    );

    obi_sram #(
        .GNT_DELAY (GNT_DELAY),
        .MEM_WORDS (MEM_WORDS)
    ) sram0 (
        .CLK  (CLK),
        .RSTn (RSTn),
        .bus  (bus0)
    );

endmodule

/* logic/obi_sram.sv */
module obi_sram import riscv_pkg::*; #(
    parameter int GNT_DELAY = 2,
    parameter int MEM_WORDS = 256
) (
    input  logic       CLK,
    input  logic       RSTn,

    obi_intf.to_proc   bus
);

    localparam int CNT_W = $clog2(GNT_DELAY + 2);
    localparam int IDX_W = $clog2(MEM_WORDS);           // Depth is a power of two

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [CNT_W-1:0] gnt_cnt;
    logic [IDX_W-1:0] word_idx;
    logic             accept;
    logic             valid_q;
    logic [XLEN-1:0]  rdata_q;

    assign word_idx = bus.addr[IDX_W+1:2];              // Wraps at the RAM depth

    // ##########################################################
    // Grant delay

    assign bus.mem_rdy = (bus.proc_req == REQUEST) && (gnt_cnt == CNT_W'(GNT_DELAY));
    assign accept      = (bus.proc_req == REQUEST) && bus.mem_rdy;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            gnt_cnt <= '0;
        end else if (bus.proc_req != REQUEST || accept) begin
            gnt_cnt <= '0;
        end else begin
            gnt_cnt <= gnt_cnt + 1'b1;                   // Stops at GNT_DELAY by the grant
        end
    end

    // ##########################################################
    // Storage

    always_ff @(posedge CLK) begin
        if (accept && bus.we) begin
            for (int i = 0; i < BE_W; i++) begin
                if (bus.be[i]) begin
                    mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept && !bus.we) begin
            rdata_q <= mem[word_idx];
        end
    end

    // One response per accepted address phase
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    assign bus.valid = valid_q;
    assign bus.rdata = rdata_q;

    // ##########################################################
    // Checks

    // Address phase held until the grant
    a_req_held : assert property (@(posedge CLK) disable iff (!RSTn)
        ((bus.proc_req == REQUEST) && !bus.mem_rdy) |=>
            (bus.proc_req == REQUEST) && $stable(bus.addr) && $stable(bus.we) &&
            $stable(bus.be) && $stable(bus.wdata));

    // No grant while a response is still out, so one access in flight
    a_no_rdy_in_resp : assert property (@(posedge CLK) disable iff (!RSTn)
        bus.mem_rdy |-> !bus.valid);

endmodule

/* logic/lsu.sv */
module lsu import riscv_pkg::*; (
    input  logic            CLK,
    input  logic            RSTn,

    input  logic            HZ_data_req,
    input  MEM_ctrl         MEM_ctrl_in,
    input  logic [XLEN-1:0] addr_in,
    input  logic [XLEN-1:0] data_in,

    output logic            busy_out,
    output logic [XLEN-1:0] data_out,

    obi_intf.to_mem         lsu_intf
);

    typedef enum logic [1:0] {
        wait_req,
        wait_ready,
        wait_valid
    } lsu_state_t;

    lsu_state_t      cur_state, nxt_state;
    req_t            req;
    logic            start;
    logic            accept;

    // Load attributes captured at acceptance
    logic [1:0]      ld_offset_q;
    mem_size_t       ld_size_q;
    logic            ld_unsigned_q;
    logic            rd_pend_q;
    logic [XLEN-1:0] ld_data;

    assign start  = MEM_ctrl_in.mem_en && HZ_data_req;
    assign accept = (req == REQUEST) && lsu_intf.mem_rdy;

    // ##########################################################
    // Handshake FSM

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            cur_state <= wait_req;
        end else begin
            cur_state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = cur_state;
        busy_out  = 1'b0;
        req       = NOREQUEST;
        case (cur_state)
            wait_req: begin
                if (start) begin
                    busy_out  = 1'b1;
                    req       = REQUEST;
                    nxt_state = lsu_intf.mem_rdy ? wait_valid : wait_ready;
                end
            end
            wait_ready: begin
                busy_out = 1'b1;
                req      = REQUEST;
                if (lsu_intf.mem_rdy) begin
                    nxt_state = wait_valid;
                end
            end
            wait_valid: begin
                busy_out = !lsu_intf.valid;              // Drops in the response cycle
                if (lsu_intf.valid) begin
                    nxt_state = wait_req;
                end
            end
            default: nxt_state = wait_req;
        endcase
    end

    // ##########################################################
    // Bus side

    assign lsu_intf.proc_req = req;
    assign lsu_intf.addr     = addr_in;
    assign lsu_intf.we       = MEM_ctrl_in.wr;

    always_ff @(posedge CLK) begin
        if (accept) begin
            ld_offset_q   <= addr_in[1:0];
            ld_size_q     <= MEM_ctrl_in.size;
            ld_unsigned_q <= MEM_ctrl_in.unsigned_ld;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            rd_pend_q <= 1'b0;
        end else if (accept) begin
            rd_pend_q <= !MEM_ctrl_in.wr;
        end
    end

    lsu_align align0 (
        .st_size     (MEM_ctrl_in.size),
        .st_offset   (addr_in[1:0]),
        .st_data     (data_in),
        .be          (lsu_intf.be),
        .wdata       (lsu_intf.wdata),
        .ld_size     (ld_size_q),
        .ld_offset   (ld_offset_q),
        .ld_unsigned (ld_unsigned_q),
        .rdata       (lsu_intf.rdata),
        .ld_data     (ld_data)
    );

    // Result held until the next load completes
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            data_out <= '0;
        end else if (lsu_intf.valid && rd_pend_q) begin
            data_out <= ld_data;
        end
    end

    // ##########################################################
    // Checks

    a_aligned : assert property (@(posedge CLK) disable iff (!RSTn)
        (req == REQUEST) |->
            ((MEM_ctrl_in.size == SIZE_WORD) ? (addr_in[1:0] == 2'b00) :
             (MEM_ctrl_in.size == SIZE_HALF) ? !addr_in[0] : 1'b1));

    a_addr_held : assert property (@(posedge CLK) disable iff (!RSTn)
        (cur_state == wait_ready) |-> $stable(lsu_intf.addr));

endmodule

/* logic/lsu_align.sv */
module lsu_align import riscv_pkg::*; (
    // Store side
    input  mem_size_t       st_size,
    input  logic [1:0]      st_offset,
    input  logic [XLEN-1:0] st_data,
    output logic [BE_W-1:0] be,
    output logic [XLEN-1:0] wdata,

    // Load side
    input  mem_size_t       ld_size,
    input  logic [1:0]      ld_offset,
    input  logic            ld_unsigned,
    input  logic [XLEN-1:0] rdata,
    output logic [XLEN-1:0] ld_data
);

    logic [XLEN-1:0] lane;

    // ##########################################################
    // Store lanes

    always_comb begin
        case (st_size)
            SIZE_BYTE: begin
                be    = 4'b0001 << st_offset;
                wdata = {4{st_data[7:0]}};               // Every lane carries the byte
            end
            SIZE_HALF: begin
                be    = st_offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{st_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = st_data;
            end
        endcase
    end

    // ##########################################################
    // Load extraction

    // Addressed byte or halfword moved down to bit 0
    assign lane = rdata >> {ld_offset, 3'b000};

    always_comb begin
        case (ld_size)
            SIZE_BYTE: begin
                if (ld_unsigned) begin
                    ld_data = {24'b0, lane[7:0]};
                end else begin
                    ld_data = {{24{lane[7]}}, lane[7:0]};
                end
            end
            SIZE_HALF: begin
                if (ld_unsigned) begin
                    ld_data = {16'b0, lane[15:0]};
                end else begin
                    ld_data = {{16{lane[15]}}, lane[15:0]};
                end
            end
            default: ld_data = rdata;                    // Word, no shift needed
        endcase
    end

endmodule

/* logic/obi_intf.sv */
interface obi_intf import riscv_pkg::*; ();

    // Address phase, driven by the LSU
    req_t              proc_req;
    logic [XLEN-1:0]   addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [XLEN-1:0]   wdata;

    // Grant and response phase, driven by the RAM
    logic              mem_rdy;
    logic              valid;
    logic [XLEN-1:0]   rdata;

    modport to_mem (
        output proc_req,
        output addr,
        output we,
        output be,
        output wdata,
        input  mem_rdy,
        input  valid,
        input  rdata
    );

    modport to_proc (
        input  proc_req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output mem_rdy,
        output valid,
        output rdata
    );

endinterface

/* logic/riscv_pkg.sv */
package riscv_pkg;

    // ##########################################################
    // Widths

    localparam int XLEN = 32;                // Data and address width

    // ##########################################################
    // Data bus request level

    typedef enum logic {
        NOREQUEST = 1'b0,
        REQUEST   = 1'b1
    } req_t;

    // ##########################################################
    // Access size, encoded like funct3[1:0] of loads and stores

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    // ##########################################################
    // Memory stage control fields from the decoder

    typedef struct packed {
        logic      mem_en;                   // Load or store in this stage
        logic      wr;                       // Store when set
        mem_size_t size;
        logic      unsigned_ld;              // LBU / LHU
    } MEM_ctrl;

    // Byte lanes in one bus word
    localparam int BE_W = XLEN / 8;

endpackage
